// File: sim.f
+incdir+bench
hw/execPkg.sv
hw/execDatapath.sv
hw/flagUnit.sv
hw/memAccess.sv
hw/execute.sv
bench/executeTb.sv

// File: bench/executeRef.svh
// Fibonacci LFSR with taps 32 22 2 1
logic [31:0] lfsrState = 32'h182f_5ebb;

function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        r = {r[30:0], fb};
    end
    return r;
endfunction

function automatic logic [31:0] sext(input logic [15:0] v);
    return {{16{v[15]}}, v};
endfunction

// Packed as {writeEnable, writeData}
function automatic logic [32:0] refWrite(input opClassT cls, input logic form, input subOpT sub,
        input movOpT mov, input logic [15:0] immV, input logic [31:0] opD, opF, opS, mem,
        input logic [3:0] fl);
    logic [31:0] b;
    b = (cls == OpDataImm) ? sext(immV) : opS;
    if (cls == OpMem) return {!form, mem};      // Loads only
    if (cls == OpBranch) return '0;
    if (cls == OpDataImm && !form) begin
        case (mov)
            MovMov:  return {1'b1, 16'h0, immV};
            MovMovt: return {1'b1, immV, opD[15:0]};
            MovClr:  return {1'b1, 32'h0};
            MovSet:  return {1'b1, 32'hffff_ffff};
            MovLsl:  return {1'b1, (immV > 31) ? 32'h0 : opF << immV[4:0]};
            MovLsr:  return {1'b1, (immV > 31) ? 32'h0 : opF >> immV[4:0]};
            MovMovf: return {1'b1, 28'h0, fl};
            default: return '0;
        endcase
    end
    if (cls == OpDataImm && sub == SubSavf) return {1'b1, 28'h0, opF[3:0]};
    case (sub)
        SubAdd, SubAdds: return {1'b1, opF + b};
        SubSub, SubSubs: return {1'b1, opF - b};
        SubAnd, SubAnds: return {1'b1, opF & b};
        SubOr, SubOrs:   return {1'b1, opF | b};
        SubXor, SubXors: return {1'b1, opF ^ b};
        SubNot:          return {1'b1, ~opF};
        default:         return '0;
    endcase
endfunction

function automatic logic [3:0] refFlags(input opClassT cls, input logic form, input subOpT sub,
        input logic [15:0] immV, input logic [31:0] opF, opS, input logic [3:0] fl);
    logic [31:0] b;
    logic [31:0] res;
    logic [3:0] f;
    longint exact;
    b = (cls == OpDataImm) ? sext(immV) : opS;
    f = fl;
    if (cls == OpDataImm && form && sub == SubSavf) return opF[3:0];
    if (cls != OpDataReg && !(cls == OpDataImm && form)) return fl;
    case (sub)
        SubAdds: begin
            res = opF + b;
            exact = longint'($signed(opF)) + longint'($signed(b));
            f[FlagC] = res < opF;       // Wrapped sum means carry
            f[FlagV] = exact != longint'($signed(res));     // Exact sum out of range
        end
        SubSubs: begin
            res = opF - b;
            exact = longint'($signed(opF)) - longint'($signed(b));
            f[FlagC] = opF >= b;        // No borrow
            f[FlagV] = exact != longint'($signed(res));
        end
        SubAnds: res = opF & b;
        SubOrs:  res = opF | b;
        SubXors: res = opF ^ b;
        default: return fl;
    endcase
    f[FlagN] = res[31];
    f[FlagZ] = (res == 0);
    return f;
endfunction

function automatic logic refBranch(input opClassT cls, input condT cnd, input logic [3:0] fl);
    logic n;
    logic z;
    logic c;
    logic v;
    n = fl[FlagN];
    z = fl[FlagZ];
    c = fl[FlagC];
    v = fl[FlagV];
    if (cls != OpBranch) return 1'b0;
    case (cnd)
        CondEq:  return z;
        CondNe:  return !z;
        CondHs:  return c;
        CondLo:  return !c;
        CondMi:  return n;
        CondPl:  return !n;
        CondVs:  return v;
        CondVc:  return !v;
        CondHi:  return c && !z;
        CondLs:  return !c || z;
        CondGe:  return n == v;
        CondLt:  return n != v;
        CondGt:  return !z && (n == v);
        CondLe:  return z || (n != v);
        default: return 1'b0;
    endcase
endfunction

// File: bench/executeTb.sv
`timescale 1ns/1ns

module executeTb import execPkg::*; ();

    logic clk;
    logic rst;
    opClassT opClass;
    logic immForm;
    subOpT subOp;
    movOpT movOp;
    condT cond;
    logic [15:0] imm;
    logic [3:0] destReg;
    logic [31:0] operandDest, operandFirst, operandSec, memDataIn;
    logic [31:0] writeData, branchTarget, memAddr, storeAddr, storeData;
    logic writeEnable, branchTaken, memRead, memWrite;
    logic [3:0] writeReg;
    logic [3:0] flags;

    // Next instruction handed to the DUT by step
    opClassT nCls;
    logic nForm;
    subOpT nSub;
    movOpT nMov;
    condT nCond;
    logic [15:0] nImm;
    logic [3:0] nDest;
    logic [31:0] nOpD, nOpF, nOpS, nMem;

    logic [3:0] modelFlags, pendFlags, expReg;
    logic pendStore, expMemWrite, expWe, expBranch, expIsBranch, expRead, checkOn;
    logic [31:0] pendAddr, pendData, expStoreAddr, expStoreData, expData, expTarget, expAddr;
    string testName;
    int errors, testErrors, testsRun, testsFailed;
    subOpT aluOps [11] = '{SubAdd, SubSub, SubAnd, SubOr, SubXor, SubNot,
                           SubAdds, SubSubs, SubAnds, SubOrs, SubXors};

    `include "executeRef.svh"

    execute UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkValue(input string what, input logic [31:0] expV,
            input logic [31:0] actV);
        assert (actV === expV) else begin
            $display("mismatch %s %s: expected %h actual %h", testName, what, expV, actV);
            errors++;
            testErrors++;
        end
    endtask

    // Outputs settle long before the falling edge
    always @(negedge clk) begin
        if (checkOn) begin
            checkValue("writeEnable", expWe, writeEnable);
            if (expWe) checkValue("writeData", expData, writeData);
            checkValue("writeReg", expReg, writeReg);
            checkValue("flags", modelFlags, flags);
            checkValue("branchTaken", expBranch, branchTaken);
            if (expIsBranch) checkValue("branchTarget", expTarget, branchTarget);
            checkValue("memRead", expRead, memRead);
            if (expRead) checkValue("memAddr", expAddr, memAddr);
            checkValue("memWrite", expMemWrite, memWrite);
            checkValue("storeAddr", expStoreAddr, storeAddr);
            checkValue("storeData", expStoreData, storeData);
        end
    end

    task automatic setIdle();
        nCls  = OpBranch;
        nForm = 1'b0;
        nCond = CondEq;
        nImm  = '0;
    endtask

    task automatic step();
        logic [32:0] wr;
        @(posedge clk);
        modelFlags  = pendFlags;    // Registers take the previous instruction
        expMemWrite = pendStore;
        if (pendStore) begin
            expStoreAddr = pendAddr;
            expStoreData = pendData;
        end
        opClass      <= nCls;
        immForm      <= nForm;
        subOp        <= nSub;
        movOp        <= nMov;
        cond         <= nCond;
        imm          <= nImm;
        destReg      <= nDest;
        operandDest  <= nOpD;
        operandFirst <= nOpF;
        operandSec   <= nOpS;
        memDataIn    <= nMem;
        wr = refWrite(nCls, nForm, nSub, nMov, nImm, nOpD, nOpF, nOpS, nMem, modelFlags);
        expWe       = wr[32];
        expData     = wr[31:0];
        expReg      = nDest;
        expBranch   = refBranch(nCls, nCond, modelFlags);
        expIsBranch = (nCls == OpBranch);
        expTarget   = sext(nImm);
        expRead     = (nCls == OpMem) && !nForm;
        expAddr     = nOpF + sext(nImm);
        pendFlags   = refFlags(nCls, nForm, nSub, nImm, nOpF, nOpS, modelFlags);
        pendStore   = (nCls == OpMem) && nForm;
        pendAddr    = expAddr;
        pendData    = nOpD;
        checkOn     = 1'b1;
    endtask

    task automatic endTest();
        setIdle();
        step();
        step();     // Flags of the last instruction checked by now
        $display("test %s: %0d errors", testName, testErrors);
        testsRun++;
        if (testErrors != 0) testsFailed++;
        testErrors = 0;
    endtask

    // Store must show up on the very next cycle
    task automatic waitStore();
        int waited;
        waited = 0;
        setIdle();
        do begin
            step();
            @(negedge clk);
            waited++;
        end while (!memWrite && waited < 4);
        if (!memWrite) begin
            $display("timeout in %s: no store write within %0d cycles", testName, waited);
            errors++;
            testErrors++;
        end else begin
            assert (waited == 1) else begin
                $display("store write in %s came after %0d cycles, not one", testName, waited);
                errors++;
                testErrors++;
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        opClass = OpBranch;
        immForm = 1'b0;
        subOp = SubAdd;
        movOp = MovMov;
        cond = CondEq;
        imm = '0;
        destReg = '0;
        operandDest = '0;
        operandFirst = '0;
        operandSec = '0;
        memDataIn = '0;
        {nOpD, nOpF, nOpS, nMem, nDest} = '0;
        nSub = SubAdd;
        nMov = MovMov;
        modelFlags = '0;
        pendFlags = '0;
        pendStore = 1'b0;
        expStoreAddr = '0;
        expStoreData = '0;
        checkOn = 1'b0;

        testName = "reset";
        repeat (7) @(posedge clk);
        @(negedge clk);
        checkValue("flags", 32'h0, 32'(flags));
        checkValue("memWrite", 32'h0, 32'(memWrite));
        checkValue("storeAddr", 32'h0, storeAddr);
        checkValue("storeData", 32'h0, storeData);
        @(posedge clk);
        rst <= 1'b0;
        endTest();

        testName = "regAlu";
        for (int i = 0; i < 200; i++) begin
            nCls  = OpDataReg;
            nForm = 1'(randBits(1));
            nSub  = aluOps[randBits(4) % 11];
            nDest = 4'(randBits(4));
            nOpF  = randBits(32);
            nOpS  = (randBits(3) == 0) ? nOpF : randBits(32);     // Some zero results
            step();
        end
        endTest();

        testName = "immAluMov";
        for (int i = 0; i < 200; i++) begin
            nCls  = OpDataImm;
            nForm = 1'(randBits(1));
            nSub  = aluOps[randBits(4) % 11];
            nMov  = movOpT'(randBits(3) % 6);
            nImm  = 16'(randBits(16));
            if (randBits(1) != 0) nImm = 16'(randBits(6));     // Half of these 32 or more
            nDest = 4'(randBits(4));
            nOpD  = randBits(32);
            nOpF  = randBits(32);
            step();
        end
        endTest();

        testName = "flagsBranch";
        for (int p = 0; p < 16; p++) begin
            nCls  = OpDataImm;
            nForm = 1'b1;
            nSub  = SubSavf;
            nOpF  = (randBits(28) << 4) | 32'(p);
            step();
            nForm = 1'b0;
            nMov  = MovMovf;
            step();
            for (int c = 0; c < 14; c++) begin
                nCls  = OpBranch;
                nCond = condT'(c);
                nImm  = 16'(randBits(16));
                step();
            end
        end
        endTest();

        testName = "memory";
        for (int i = 0; i < 20; i++) begin
            nCls  = OpMem;
            nForm = 1'b0;
            nImm  = 16'(randBits(16));
            nOpF  = randBits(32);
            nMem  = randBits(32);
            nDest = 4'(randBits(4));
            step();
            nCls  = OpMem;
            nForm = 1'b1;
            nImm  = 16'(randBits(16));
            nOpD  = randBits(32);
            step();
            waitStore();
        end
        endTest();

        @(posedge clk);
        checkOn = 1'b0;
        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: hw/execute.sv
`timescale 1ns/1ns

module execute import execPkg::*; #(
    parameter int dataWidth = DataWidth,
    parameter int immWidth  = ImmWidth
) (
    input  logic                   clk,
    input  logic                   rst,
    input  opClassT                opClass,
    input  logic                   immForm,
    input  subOpT                  subOp,
    input  movOpT                  movOp,
    input  condT                   cond,
    input  logic [immWidth-1:0]    imm,
    input  logic [RegIdxWidth-1:0] destReg,
    input  logic [dataWidth-1:0]   operandDest,
    input  logic [dataWidth-1:0]   operandFirst,
    input  logic [dataWidth-1:0]   operandSec,
    input  logic [dataWidth-1:0]   memDataIn,
    output logic [dataWidth-1:0]   writeData,
    output logic                   writeEnable,
    output logic [RegIdxWidth-1:0] writeReg,
    output logic                   branchTaken,
    output logic [dataWidth-1:0]   branchTarget,
    output logic [3:0]             flags,
    output logic [dataWidth-1:0]   memAddr,
    output logic                   memRead,
    output logic [dataWidth-1:0]   storeAddr,
    output logic [dataWidth-1:0]   storeData,
    output logic                   memWrite
);

    // Flag update strobes from the data path
    logic       flagNzLoad;
    logic       flagCvLoad;
    logic       flagSaveLoad;
    logic [3:0] flagNext;

    execDatapath #(.dataWidth(dataWidth), .immWidth(immWidth)) datapath (
        .opClass, .immForm, .subOp, .movOp, .imm, .destReg,
        .operandDest, .operandFirst, .operandSec, .memDataIn, .flags,
        .writeData, .writeEnable, .writeReg,
        .flagNzLoad, .flagCvLoad, .flagSaveLoad, .flagNext
    );

    flagUnit #(.dataWidth(dataWidth), .immWidth(immWidth)) flagState (
        .clk, .rst, .opClass, .cond, .imm,
        .flagNzLoad, .flagCvLoad, .flagSaveLoad, .flagNext,
        .flags, .branchTaken, .branchTarget
    );

    memAccess #(.dataWidth(dataWidth), .immWidth(immWidth)) memPort (
        .clk, .rst, .opClass, .immForm, .imm, .operandFirst, .operandDest,
        .memAddr, .memRead, .storeAddr, .storeData, .memWrite
    );

endmodule

// File: hw/memAccess.sv
`timescale 1ns/1ns

module memAccess import execPkg::*; #(
    parameter int dataWidth = DataWidth,
    parameter int immWidth  = ImmWidth
) (
    input  logic                 clk,
    input  logic                 rst,
    input  opClassT              opClass,
    input  logic                 immForm,
    input  logic [immWidth-1:0]  imm,
    input  logic [dataWidth-1:0] operandFirst,
    input  logic [dataWidth-1:0] operandDest,
    output logic [dataWidth-1:0] memAddr,
    output logic                 memRead,
    output logic [dataWidth-1:0] storeAddr,
    output logic [dataWidth-1:0] storeData,
    output logic                 memWrite
);

    logic isStore;

    // Base plus signed offset
    assign memAddr = operandFirst + dataWidth'($signed(imm));

    assign memRead = (opClass == OpMem) && !immForm;
    assign isStore = (opClass == OpMem) && immForm;

    // Store goes out one cycle after the instruction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            memWrite  <= 1'b0;
            storeAddr <= '0;
            storeData <= '0;
        end else begin
            memWrite <= isStore;    // Single-cycle pulse per store
            if (isStore) begin
                storeAddr <= memAddr;
                storeData <= operandDest;
            end
        end
    end

endmodule

// File: hw/flagUnit.sv
`timescale 1ns/1ns

module flagUnit import execPkg::*; #(
    parameter int dataWidth = DataWidth,
    parameter int immWidth  = ImmWidth
) (
    input  logic                 clk,
    input  logic                 rst,
    input  opClassT              opClass,
    input  condT                 cond,
    input  logic [immWidth-1:0]  imm,
    input  logic                 flagNzLoad,
    input  logic                 flagCvLoad,
    input  logic                 flagSaveLoad,
    input  logic [3:0]           flagNext,
    output logic [3:0]           flags,
    output logic                 branchTaken,
    output logic [dataWidth-1:0] branchTarget
);

    logic nBit;
    logic zBit;
    logic cBit;
    logic vBit;
    logic condMet;

    // NZCV register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= 4'b0000;
        end else if (flagSaveLoad) begin
            flags <= flagNext;      // SAVF loads all four
        end else begin
            if (flagNzLoad) begin
                flags[FlagN] <= flagNext[FlagN];
                flags[FlagZ] <= flagNext[FlagZ];
            end
            if (flagCvLoad) begin
                flags[FlagC] <= flagNext[FlagC];
                flags[FlagV] <= flagNext[FlagV];
            end
        end
    end

    assign nBit = flags[FlagN];
    assign zBit = flags[FlagZ];
    assign cBit = flags[FlagC];
    assign vBit = flags[FlagV];

    always_comb begin
        case (cond)
            CondEq:  condMet = zBit;
            CondNe:  condMet = !zBit;
            CondHs:  condMet = cBit;
            CondLo:  condMet = !cBit;
            CondMi:  condMet = nBit;
            CondPl:  condMet = !nBit;
            CondVs:  condMet = vBit;
            CondVc:  condMet = !vBit;
            CondHi:  condMet = !zBit && cBit;
            CondLs:  condMet = !(!zBit && cBit);
            CondGe:  condMet = (nBit == vBit);
            CondLt:  condMet = (nBit != vBit);
            CondGt:  condMet = !zBit && (nBit == vBit);
            CondLe:  condMet = !(!zBit && (nBit == vBit));
            default: condMet = 1'b0;
        endcase
    end

    assign branchTaken  = (opClass == OpBranch) && condMet;
    assign branchTarget = dataWidth'($signed(imm));     // Absolute target

endmodule

// File: hw/execDatapath.sv
`timescale 1ns/1ns

module execDatapath import execPkg::*; #(
    parameter int dataWidth = DataWidth,
    parameter int immWidth  = ImmWidth
) (
    input  opClassT                opClass,
    input  logic                   immForm,
    input  subOpT                  subOp,
    input  movOpT                  movOp,
    input  logic [immWidth-1:0]    imm,
    input  logic [RegIdxWidth-1:0] destReg,
    input  logic [dataWidth-1:0]   operandDest,
    input  logic [dataWidth-1:0]   operandFirst,
    input  logic [dataWidth-1:0]   operandSec,
    input  logic [dataWidth-1:0]   memDataIn,
    input  logic [3:0]             flags,
    output logic [dataWidth-1:0]   writeData,
    output logic                   writeEnable,
    output logic [RegIdxWidth-1:0] writeReg,
    output logic                   flagNzLoad,
    output logic                   flagCvLoad,
    output logic                   flagSaveLoad,
    output logic [3:0]             flagNext
);

    localparam int Msb = dataWidth - 1;

    logic [dataWidth-1:0] immSext;
    logic [dataWidth-1:0] immZext;
    logic [dataWidth-1:0] lowMask;
    logic [dataWidth-1:0] opB;
    logic [dataWidth:0]   sum;
    logic [dataWidth:0]   diff;
    logic                 addOverflow;
    logic                 subOverflow;
    logic [dataWidth-1:0] aluResult;
    logic                 aluCarry;
    logic                 aluOverflow;
    logic                 aluValid;
    logic                 aluSetNz;
    logic                 aluSetCv;
    logic [dataWidth-1:0] movResult;
    logic                 movValid;

    assign immSext = dataWidth'($signed(imm));
    assign immZext = dataWidth'(imm);
    assign lowMask = {dataWidth{1'b1}} >> immWidth;   // Bits below the MOVT field

    // Immediate form takes the sign-extended immediate as second operand
    assign opB  = (opClass == OpDataImm) ? immSext : operandSec;
    assign sum  = {1'b0, operandFirst} + {1'b0, opB};
    assign diff = {1'b0, operandFirst} - {1'b0, opB};

    assign addOverflow = (operandFirst[Msb] == opB[Msb]) && (sum[Msb] != operandFirst[Msb]);
    assign subOverflow = (operandFirst[Msb] != opB[Msb]) && (diff[Msb] != operandFirst[Msb]);

    assign writeReg = destReg;

    always_comb begin
        aluResult   = sum[Msb:0];
        aluCarry    = sum[dataWidth];
        aluOverflow = addOverflow;
        aluValid    = 1'b1;
        aluSetNz    = subOp[3];     // S forms
        aluSetCv    = 1'b0;
        case (subOp)
            SubAdd, SubAdds: aluSetCv = subOp[3];
            SubSub, SubSubs: begin
                aluResult   = diff[Msb:0];
                aluCarry    = ~diff[dataWidth];     // Not borrow
                aluOverflow = subOverflow;
                aluSetCv    = subOp[3];
            end
            SubAnd, SubAnds: aluResult = operandFirst & opB;
            SubOr,  SubOrs:  aluResult = operandFirst | opB;
            SubXor, SubXors: aluResult = operandFirst ^ opB;
            SubNot:          aluResult = ~operandFirst;
            default: begin
                aluValid = 1'b0;
                aluSetNz = 1'b0;
            end
        endcase
    end

    // MOV family
    always_comb begin
        movValid  = 1'b1;
        movResult = '0;
        case (movOp)
            MovMov:  movResult = immZext;
            MovMovt: movResult = (immZext << (dataWidth - immWidth)) | (operandDest & lowMask);
            MovClr:  movResult = '0;
            MovSet:  movResult = '1;
            MovLsl:  movResult = operandFirst << imm;   // Whole imm, wide shifts give zero
            MovLsr:  movResult = operandFirst >> imm;
            MovMovf: movResult = dataWidth'(flags);
            default: movValid  = 1'b0;
        endcase
    end

    always_comb begin
        writeData    = aluResult;
        writeEnable  = 1'b0;
        flagNzLoad   = 1'b0;
        flagCvLoad   = 1'b0;
        flagSaveLoad = 1'b0;

        flagNext[FlagN] = aluResult[Msb];
        flagNext[FlagZ] = (aluResult == '0);
        flagNext[FlagC] = aluCarry;
        flagNext[FlagV] = aluOverflow;

        case (opClass)
            OpDataImm: begin
                if (!immForm) begin
                    writeData   = movResult;
                    writeEnable = movValid;
                end else if (subOp == SubSavf) begin
                    // Flags from the low nibble, nibble written back
                    writeData    = dataWidth'(operandFirst[3:0]);
                    writeEnable  = 1'b1;
                    flagSaveLoad = 1'b1;
                    flagNext     = operandFirst[3:0];
                end else begin
                    writeEnable = aluValid;
                    flagNzLoad  = aluSetNz;
                    flagCvLoad  = aluSetCv;
                end
            end
            OpDataReg: begin    // immForm ignored here
                writeEnable = aluValid;
                flagNzLoad  = aluSetNz;
                flagCvLoad  = aluSetCv;
            end
            OpMem: begin
                if (!immForm) begin     // Load
                    writeData   = memDataIn;
                    writeEnable = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: hw/execPkg.sv
package execPkg;

    localparam int DataWidth   = 32;    // Register data
    localparam int ImmWidth    = 16;    // Immediate field
    localparam int RegIdxWidth = 4;

    // NZCV bit positions
    localparam int FlagN = 3;
    localparam int FlagZ = 2;
    localparam int FlagC = 1;
    localparam int FlagV = 0;

    typedef enum logic [1:0] {
        OpDataImm = 2'b00,
        OpDataReg = 2'b01,
        OpMem     = 2'b10,
        OpBranch  = 2'b11
    } opClassT;

    // Bit 3 marks the flag-setting forms
    typedef enum logic [3:0] {
        SubAdd  = 4'b0001, SubSub  = 4'b0010, SubAnd  = 4'b0011,
        SubOr   = 4'b0100, SubXor  = 4'b0101, SubNot  = 4'b0110,
        SubAdds = 4'b1001, SubSubs = 4'b1010, SubAnds = 4'b1011,
        SubOrs  = 4'b1100, SubXors = 4'b1101, SubSavf = 4'b1110
    } subOpT;

    typedef enum logic [2:0] {
        MovMov  = 3'b000, MovMovt = 3'b001, MovClr  = 3'b010, MovSet = 3'b011,
        MovLsl  = 3'b100, MovLsr  = 3'b101, MovMovf = 3'b110
    } movOpT;

    typedef enum logic [3:0] {
        CondEq = 4'b0000, CondNe = 4'b0001, CondHs = 4'b0010, CondLo = 4'b0011,
        CondMi = 4'b0100, CondPl = 4'b0101, CondVs = 4'b0110, CondVc = 4'b0111,
        CondHi = 4'b1000, CondLs = 4'b1001, CondGe = 4'b1010, CondLt = 4'b1011,
        CondGt = 4'b1100, CondLe = 4'b1101
    } condT;

endpackage
